// File: design/rv_pkg.sv
// shared types and constants for the RV32I core
// only word-sized LOAD/STORE exist, byte and half accesses are not decoded
// OUT_ADDR and HALT_ADDR are claimed by the core and never reach memory
package rv_pkg;

    localparam int XLEN = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [4:0]      reg_sel_t;
    typedef logic [31:0]     instr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;

    // major opcodes kept from the base set
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    // funct3 for OP and OP-IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct3 for branches
    localparam funct3_t BR_BEQ  = 3'b000;
    localparam funct3_t BR_BNE  = 3'b001;
    localparam funct3_t BR_BLT  = 3'b100;
    localparam funct3_t BR_BGE  = 3'b101;
    localparam funct3_t BR_BLTU = 3'b110;
    localparam funct3_t BR_BGEU = 3'b111;

    localparam addr_t OUT_ADDR    = 32'd1000;
    localparam addr_t HALT_ADDR   = 32'd1004;
    localparam addr_t RESET_PC    = 32'd0;
    localparam addr_t INSTR_BYTES = 32'd4;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM_WAIT,
        ST_OUT_WAIT,
        ST_HALTED
    } core_state_t;

endpackage

// File: design/instr_decode.sv
// purely combinational instruction decoder
// opcodes outside the kept RV32I subset only lower known_op,
// the ALU operation then falls back to add and is ignored
`timescale 1ns/1ps

module instr_decode import rv_pkg::*; (
    input  instr_t   instr,
    output opcode_t  opcode,
    output reg_sel_t rd,
    output reg_sel_t rs1,
    output reg_sel_t rs2,
    output funct3_t  funct3,
    output word_t    imm_i,
    output word_t    imm_s,
    output word_t    imm_b,
    output word_t    imm_u,
    output alu_op_t  alu_op,
    output logic     use_imm,
    output logic     known_op
);

    // fixed field positions of the base encoding
    always_comb begin
        opcode = instr[6:0];
        rd     = instr[11:7];
        funct3 = instr[14:12];
        rs1    = instr[19:15];
        rs2    = instr[24:20];

        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        // branch offsets are in halfwords, bit 0 always zero
        imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'b0};
    end

    always_comb begin
        alu_op = ALU_ADD;
        case (opcode)
            OPC_OP_IMM, OPC_OP: begin
                case (funct3)
                    // bit 30 selects SUB only for register operands, ADDI has no SUBI
                    F3_ADD:  alu_op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_SLTU: alu_op = ALU_SLTU;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_SR:   alu_op = instr[30] ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OPC_LUI: alu_op = ALU_PASS_B;
            default: alu_op = ALU_ADD;
        endcase
    end

    // shift amounts of SLLI/SRLI/SRAI sit in imm_i[4:0]
    assign use_imm = (opcode == OPC_OP_IMM) || (opcode == OPC_LOAD) ||
                     (opcode == OPC_LUI) || (opcode == OPC_AUIPC);

    assign known_op = (opcode == OPC_OP_IMM) || (opcode == OPC_OP) ||
                      (opcode == OPC_LOAD) || (opcode == OPC_STORE) ||
                      (opcode == OPC_BRANCH) || (opcode == OPC_LUI) ||
                      (opcode == OPC_AUIPC);

endmodule

// File: design/int_alu.sv
// integer ALU plus a separate branch comparator
// take_branch is only meaningful while a branch is executing,
// funct3 codes that are not branches give no branch
`timescale 1ns/1ps

module int_alu import rv_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   a,
    input  word_t   b,
    input  funct3_t funct3,
    output word_t   result,
    output logic    take_branch
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLT:    result = {31'b0, lt_signed};
            ALU_SLTU:   result = {31'b0, lt_unsigned};
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLL:    result = a << shamt;
            ALU_SRL:    result = a >> shamt;
            // sign bit is copied in from the left
            ALU_SRA:    result = word_t'($signed(a) >>> shamt);
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    // branch compare shares the comparators but not the result mux
    always_comb begin
        case (funct3)
            BR_BEQ:  take_branch = (a == b);
            BR_BNE:  take_branch = (a != b);
            BR_BLT:  take_branch = lt_signed;
            BR_BGE:  take_branch = !lt_signed;
            BR_BLTU: take_branch = lt_unsigned;
            BR_BGEU: take_branch = !lt_unsigned;
            default: take_branch = 1'b0;
        endcase
    end

    // decoder must only hand over one of the defined operations
    always_comb begin
        if (!$isunknown(alu_op)) begin
            assert (alu_op inside {ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
                                   ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
                                   ALU_PASS_B})
            else $error("int_alu: undefined alu_op %0d", alu_op);
        end
    end

endmodule

// File: design/reg_file.sv
// 31 general registers, x0 is hardwired to zero
// reads are combinational, a write lands on the next rising edge
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_sel_t rs1_sel,
    input  reg_sel_t rs2_sel,
    input  logic     wr_en,
    input  reg_sel_t wr_sel,
    input  word_t    wr_data,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    // no storage for x0
    word_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;
        end
    end

    assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

    // a write with an X select would smear across the array
    a_wr_sel_known: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wr_sel)
    ) else $error("reg_file: write select unknown");

endmodule

// File: design/core_control.sv
// sequencing for a non-pipelined core, one instruction in flight
// memory and output requests come straight from the state, so they
// hold until mem_ack / out_ready without extra registers
// halted is sticky until reset
`timescale 1ns/1ps

module core_control import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  opcode_t  opcode,
    input  reg_sel_t rd,
    input  word_t    imm_i,
    input  word_t    imm_s,
    input  word_t    imm_b,
    input  word_t    imm_u,
    input  logic     use_imm,
    input  logic     known_op,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  word_t    alu_result,
    input  logic     take_branch,
    input  word_t    mem_rd_data,
    input  logic     mem_ack,
    input  logic     out_ready,
    output instr_t   instr,
    output word_t    alu_a,
    output word_t    alu_b,
    output logic     rf_wr_en,
    output reg_sel_t rf_wr_sel,
    output word_t    rf_wr_data,
    output addr_t    mem_addr,
    output word_t    mem_wr_data,
    output logic     mem_rd_req,
    output logic     mem_wr_req,
    output word_t    out_data,
    output logic     out_valid,
    output logic     halted
);

    core_state_t state;
    addr_t       pc;
    addr_t       pc_seq;
    addr_t       ls_addr;
    addr_t       ls_addr_q;
    word_t       st_data_q;
    logic        is_load_q;
    logic        writes_alu;

    assign pc_seq = pc + INSTR_BYTES;

    // load uses the I immediate, store the S immediate
    assign ls_addr = rs1_data + ((opcode == OPC_STORE) ? imm_s : imm_i);

    assign writes_alu = (opcode == OPC_OP) || (opcode == OPC_OP_IMM) ||
                        (opcode == OPC_LUI) || (opcode == OPC_AUIPC);

    // operand select, AUIPC adds to pc and LUI passes imm_u through
    always_comb begin
        alu_a = (opcode == OPC_AUIPC) ? pc : rs1_data;
        if (!use_imm) begin
            alu_b = rs2_data;
        end else if (opcode == OPC_LUI || opcode == OPC_AUIPC) begin
            alu_b = imm_u;
        end else begin
            alu_b = imm_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_FETCH;
            pc    <= RESET_PC;
            instr <= '0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (mem_ack) begin
                        instr <= mem_rd_data;
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (!known_op) begin
                        state <= ST_HALTED;
                    end else if (opcode == OPC_LOAD) begin
                        state <= ST_MEM_WAIT;
                    end else if (opcode == OPC_STORE) begin
                        if (ls_addr == OUT_ADDR) begin
                            state <= ST_OUT_WAIT;
                        end else if (ls_addr == HALT_ADDR) begin
                            state <= ST_HALTED;
                        end else begin
                            state <= ST_MEM_WAIT;
                        end
                    end else begin
                        // branch or register op finishes here
                        pc    <= (opcode == OPC_BRANCH && take_branch) ? pc + imm_b : pc_seq;
                        state <= ST_FETCH;
                    end
                end
                ST_MEM_WAIT: begin
                    if (mem_ack) begin
                        pc    <= pc_seq;
                        state <= ST_FETCH;
                    end
                end
                ST_OUT_WAIT: begin
                    if (out_ready) begin
                        pc    <= pc_seq;
                        state <= ST_FETCH;
                    end
                end
                default: state <= ST_HALTED;
            endcase
        end
    end

    // access details captured at exec, held through the wait states
    always_ff @(posedge clk) begin
        if (state == ST_EXEC) begin
            ls_addr_q <= ls_addr;
            st_data_q <= rs2_data;
            is_load_q <= (opcode == OPC_LOAD);
        end
    end

    // memory port
    always_comb begin
        mem_addr    = pc;
        mem_wr_data = st_data_q;
        mem_rd_req  = 1'b0;
        mem_wr_req  = 1'b0;
        if (state == ST_FETCH) begin
            mem_rd_req = 1'b1;
        end else if (state == ST_MEM_WAIT) begin
            mem_addr   = ls_addr_q;
            mem_rd_req = is_load_q;
            mem_wr_req = !is_load_q;
        end
    end

    assign out_data  = st_data_q;
    assign out_valid = (state == ST_OUT_WAIT);
    assign halted    = (state == ST_HALTED);

    // rd stays decoded from the held instruction during mem_wait
    assign rf_wr_sel  = rd;
    assign rf_wr_en   = (state == ST_EXEC && writes_alu) ||
                        (state == ST_MEM_WAIT && is_load_q && mem_ack);
    assign rf_wr_data = (state == ST_MEM_WAIT) ? mem_rd_data : alu_result;

    a_mem_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (mem_rd_req || mem_wr_req) && !mem_ack |=> $stable(mem_addr)
    ) else $error("core_control: mem_addr moved while request pending");

    a_out_valid_held: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("core_control: output word withdrawn before transfer");

endmodule

// File: design/rv_core.sv
// RV32I subset core, top level
// memory uses a req/ack handshake, results leave through a valid/ready port
// a store to address 1004 or an unknown opcode stops the core until reset
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t mem_rd_data,
    input  logic  mem_ack,
    input  logic  out_ready,
    output addr_t mem_addr,
    output word_t mem_wr_data,
    output logic  mem_rd_req,
    output logic  mem_wr_req,
    output word_t out_data,
    output logic  out_valid,
    output logic  halted
);

    instr_t   instr;
    opcode_t  opcode;
    reg_sel_t rd;
    reg_sel_t rs1;
    reg_sel_t rs2;
    funct3_t  funct3;
    word_t    imm_i;
    word_t    imm_s;
    word_t    imm_b;
    word_t    imm_u;
    alu_op_t  alu_op;
    logic     use_imm;
    logic     known_op;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    logic     take_branch;
    logic     rf_wr_en;
    reg_sel_t rf_wr_sel;
    word_t    rf_wr_data;

    instr_decode decode0 (
        .instr(instr), .opcode(opcode), .rd(rd), .rs1(rs1), .rs2(rs2),
        .funct3(funct3), .imm_i(imm_i), .imm_s(imm_s), .imm_b(imm_b),
        .imm_u(imm_u), .alu_op(alu_op), .use_imm(use_imm), .known_op(known_op)
    );

    reg_file regs0 (
        .clk(clk), .rst(rst), .rs1_sel(rs1), .rs2_sel(rs2),
        .wr_en(rf_wr_en), .wr_sel(rf_wr_sel), .wr_data(rf_wr_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    // for a branch the operand mux passes rs1 and rs2 through to the compare
    int_alu alu0 (
        .alu_op(alu_op), .a(alu_a), .b(alu_b), .funct3(funct3),
        .result(alu_result), .take_branch(take_branch)
    );

    core_control ctrl0 (
        .clk(clk), .rst(rst), .opcode(opcode), .rd(rd),
        .imm_i(imm_i), .imm_s(imm_s), .imm_b(imm_b), .imm_u(imm_u),
        .use_imm(use_imm), .known_op(known_op),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_result(alu_result), .take_branch(take_branch),
        .mem_rd_data(mem_rd_data), .mem_ack(mem_ack), .out_ready(out_ready),
        .instr(instr), .alu_a(alu_a), .alu_b(alu_b),
        .rf_wr_en(rf_wr_en), .rf_wr_sel(rf_wr_sel), .rf_wr_data(rf_wr_data),
        .mem_addr(mem_addr), .mem_wr_data(mem_wr_data),
        .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req),
        .out_data(out_data), .out_valid(out_valid), .halted(halted)
    );

endmodule

// File: tests/tb_ref_model.svh
// test program image and an instruction-level reference interpreter
// the program starts at address 0 and data lives at byte address 512
// included inside tb_rv_core, uses its image, ref_mem and exp_out
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic instr_t enc_r(funct3_t f3, bit alt, int rd, int rs1, int rs2);
    return {1'b0, alt, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
endfunction

function automatic instr_t enc_i(opcode_t opc, funct3_t f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
endfunction

function automatic instr_t enc_s(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic instr_t enc_b(funct3_t f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic instr_t enc_u(opcode_t opc, int rd, int imm20);
    return {imm20[19:0], rd[4:0], opc};
endfunction

function automatic void emit(instr_t w);
    image[prog_len] = w;
    prog_len++;
endfunction

// instruction followed by a store of its rd to the output port
function automatic void emit_out(instr_t w);
    emit(w);
    emit(enc_s(int'(w[11:7]), 0, OUT_ADDR));
endfunction

task automatic build_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
        image[i] = 32'hc0de_0000 ^ (32'(i) << 2);
    end
    prog_len = 0;
    emit(enc_i(OPC_OP_IMM, F3_ADD, 1, 0, -7));
    emit(enc_i(OPC_OP_IMM, F3_ADD, 2, 0, 3));
    // register operations with x1 = -7, x2 = 3
    emit_out(enc_r(F3_ADD, 1'b0, 3, 1, 2));
    emit_out(enc_r(F3_ADD, 1'b1, 3, 1, 2));
    emit_out(enc_r(F3_SLL, 1'b0, 3, 1, 2));
    emit_out(enc_r(F3_SLT, 1'b0, 3, 1, 2));
    emit_out(enc_r(F3_SLTU, 1'b0, 3, 1, 2));
    emit_out(enc_r(F3_XOR, 1'b0, 3, 1, 2));
    emit_out(enc_r(F3_SR, 1'b0, 3, 1, 2));
    emit_out(enc_r(F3_SR, 1'b1, 3, 1, 2));
    emit_out(enc_r(F3_OR, 1'b0, 3, 1, 2));
    emit_out(enc_r(F3_AND, 1'b0, 3, 1, 2));
    // immediate operations, SRAI carries bit 10 of the immediate
    emit_out(enc_i(OPC_OP_IMM, F3_ADD, 3, 1, 100));
    emit_out(enc_i(OPC_OP_IMM, F3_SLT, 3, 1, -5));
    emit_out(enc_i(OPC_OP_IMM, F3_SLTU, 3, 1, 5));
    emit_out(enc_i(OPC_OP_IMM, F3_XOR, 3, 1, 32'h555));
    emit_out(enc_i(OPC_OP_IMM, F3_OR, 3, 1, 32'h0f0));
    emit_out(enc_i(OPC_OP_IMM, F3_AND, 3, 1, 32'h7f0));
    emit_out(enc_i(OPC_OP_IMM, F3_SLL, 3, 1, 4));
    emit_out(enc_i(OPC_OP_IMM, F3_SR, 3, 1, 28));
    emit_out(enc_i(OPC_OP_IMM, F3_SR, 3, 1, 32'h402));
    // one counting loop per branch type, body plus output then branch back
    emit(enc_i(OPC_OP_IMM, F3_ADD, 4, 0, 0));
    emit_out(enc_i(OPC_OP_IMM, F3_ADD, 4, 4, 1));
    emit(enc_b(BR_BLT, 4, 2, -8));
    emit(enc_i(OPC_OP_IMM, F3_ADD, 5, 0, 3));
    emit_out(enc_i(OPC_OP_IMM, F3_ADD, 5, 5, -1));
    emit(enc_b(BR_BNE, 5, 0, -8));
    emit(enc_i(OPC_OP_IMM, F3_ADD, 6, 0, -2));
    emit_out(enc_i(OPC_OP_IMM, F3_ADD, 6, 6, 1));
    emit(enc_b(BR_BGE, 0, 6, -8));
    emit(enc_i(OPC_OP_IMM, F3_ADD, 7, 0, -10));
    emit_out(enc_i(OPC_OP_IMM, F3_ADD, 7, 7, 1));
    emit(enc_b(BR_BLTU, 7, 1, -8));
    emit(enc_i(OPC_OP_IMM, F3_ADD, 8, 0, 5));
    emit_out(enc_i(OPC_OP_IMM, F3_ADD, 8, 8, -2));
    emit(enc_b(BR_BGEU, 8, 2, -8));
    // taken beq skips one output, untaken beq falls through to one
    emit(enc_b(BR_BEQ, 0, 0, 8));
    emit(enc_s(1, 0, OUT_ADDR));
    emit(enc_b(BR_BEQ, 1, 2, 8));
    emit(enc_s(2, 0, OUT_ADDR));
    // store and load round trip through the data area
    emit(enc_i(OPC_OP_IMM, F3_ADD, 10, 0, 512));
    emit(enc_s(1, 10, 0));
    emit(enc_s(2, 10, 4));
    emit_out(enc_i(OPC_LOAD, 3'b010, 11, 10, 0));
    emit_out(enc_i(OPC_LOAD, 3'b010, 12, 10, 4));
    emit_out(enc_r(F3_ADD, 1'b0, 13, 11, 12));
    emit(enc_s(13, 10, 8));
    emit_out(enc_i(OPC_LOAD, 3'b010, 14, 10, 8));
    emit_out(enc_u(OPC_LUI, 15, 32'habcde));
    emit_out(enc_u(OPC_AUIPC, 16, 32'h1));
    emit(enc_s(0, 0, HALT_ADDR));
    // never reached
    emit(enc_s(1, 0, OUT_ADDR));
endtask

// runs the program on ref_mem, returns 1 when it halts
function automatic bit run_reference();
    word_t  x [0:31];
    addr_t  pc;
    addr_t  next_pc;
    addr_t  ea;
    instr_t ins;
    word_t  a;
    word_t  b;
    word_t  r;
    word_t  imm;
    bit     wr;
    bit     taken;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    pc = RESET_PC;
    for (int step = 0; step < MAX_STEPS; step++) begin
        ins     = ref_mem[pc[9:2]];
        a       = x[ins[19:15]];
        imm     = {{20{ins[31]}}, ins[31:20]};
        b       = (ins[6:0] == OPC_OP) ? x[ins[24:20]] : imm;
        next_pc = pc + 32'd4;
        wr      = 1'b1;
        r       = '0;
        case (ins[6:0])
            OPC_OP, OPC_OP_IMM: begin
                case (ins[14:12])
                    3'b000: r = (ins[6:0] == OPC_OP && ins[30]) ? a - b : a + b;
                    3'b001: r = a << b[4:0];
                    3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011: r = (a < b) ? 32'd1 : 32'd0;
                    3'b100: r = a ^ b;
                    3'b101: begin
                        if (ins[30])
                            r = $signed(a) >>> b[4:0];
                        else
                            r = a >> b[4:0];
                    end
                    3'b110: r = a | b;
                    default: r = a & b;
                endcase
            end
            OPC_LUI: r = {ins[31:12], 12'b0};
            OPC_AUIPC: r = pc + {ins[31:12], 12'b0};
            OPC_LOAD: begin
                ea = a + imm;
                r  = ref_mem[ea[9:2]];
            end
            OPC_STORE: begin
                wr = 1'b0;
                ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                if (ea == OUT_ADDR)
                    exp_out.push_back(x[ins[24:20]]);
                else if (ea == HALT_ADDR)
                    return 1'b1;
                else
                    ref_mem[ea[9:2]] = x[ins[24:20]];
            end
            OPC_BRANCH: begin
                wr = 1'b0;
                b  = x[ins[24:20]];
                case (ins[14:12])
                    BR_BEQ:  taken = (a == b);
                    BR_BNE:  taken = (a != b);
                    BR_BLT:  taken = $signed(a) < $signed(b);
                    BR_BGE:  taken = $signed(a) >= $signed(b);
                    BR_BLTU: taken = a < b;
                    BR_BGEU: taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken)
                    next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            default: return 1'b1;
        endcase
        if (wr && ins[11:7] != 5'd0)
            x[ins[11:7]] = r;
        pc = next_pc;
    end
    return 1'b0;
endfunction

`endif

// File: tests/tb_rv_core.sv
// testbench for rv_core with a 1 KiB word memory model and an output sink
// memory ack comes 1 to 4 cycles after a request is seen, picked by an LCG
// out_ready is low about a third of the cycles
// expected outputs and final memory come from the reference interpreter
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

    localparam int MEM_WORDS  = 256;
    localparam int MAX_STEPS  = 2000;
    localparam int HALT_WATCH = 50;
    // about 90 instructions run, each at most about 12 cycles with waits
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] LCG_SEED = 32'h67da_439d;

    logic  clk;
    logic  rst;
    word_t mem_rd_data = '0;
    logic  mem_ack = 1'b0;
    logic  out_ready = 1'b0;
    addr_t mem_addr;
    word_t mem_wr_data;
    logic  mem_rd_req;
    logic  mem_wr_req;
    word_t out_data;
    logic  out_valid;
    logic  halted;

    word_t       image [0:MEM_WORDS-1];
    word_t       mem [0:MEM_WORDS-1];
    word_t       ref_mem [0:MEM_WORDS-1];
    word_t       exp_out [$];
    int          prog_len = 0;
    bit          ref_halt;
    int          error_count = 0;
    int          out_count = 0;
    int          cycle_count = 0;
    logic [31:0] rng = LCG_SEED;
    logic [1:0]  wait_left = 2'd0;

    `include "tb_ref_model.svh"

    rv_core dut0 (
        .clk(clk), .rst(rst), .mem_rd_data(mem_rd_data), .mem_ack(mem_ack),
        .out_ready(out_ready), .mem_addr(mem_addr), .mem_wr_data(mem_wr_data),
        .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req), .out_data(out_data),
        .out_valid(out_valid), .halted(halted)
    );

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_out_word(word_t got, word_t exp);
        if (got !== exp) begin
            $display("Error at %0t: output %0d is %h, expected %h", $time, out_count, got, exp);
            error_count++;
        end
    endtask

    task automatic check_mem_word(addr_t addr, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Error at %0t: memory %h holds %h, expected %h", $time, addr, got, exp);
            error_count++;
        end
    endtask

    task automatic check_out_count(int got, int exp);
        if (got != exp) begin
            $display("Error at %0t: %0d output words seen, expected %0d", $time, got, exp);
            error_count++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        rng       <= lcg_next(rng);
        out_ready <= (rng[31:16] % 16'd3) != 16'd0;
    end

    // word memory, loaded from the program image while reset is high
    always @(posedge clk) begin
        if (rst) begin
            mem_ack   <= 1'b0;
            wait_left <= 2'd0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= image[i];
            end
        end else if ((mem_rd_req || mem_wr_req) && !mem_ack) begin
            if (mem_addr >= 32'd1024) begin
                $display("core accessed address %h outside the memory model", mem_addr);
                error_count++;
            end
            if (wait_left == 2'd0) begin
                mem_ack     <= 1'b1;
                mem_rd_data <= mem[mem_addr[9:2]];
                if (mem_wr_req)
                    mem[mem_addr[9:2]] <= mem_wr_data;
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end else begin
            mem_ack   <= 1'b0;
            wait_left <= rng[17:16];
        end
    end

    // output sink, every transfer is checked in order
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (out_count < exp_out.size()) begin
                check_out_word(out_data, exp_out[out_count]);
            end else begin
                $display("Error at %0t: extra output word %h", $time, out_data);
                error_count++;
            end
            out_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = image[i];
        end
        ref_halt = run_reference();
        if (!ref_halt) begin
            $display("reference interpreter never reached a halt");
            error_count++;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        while (!halted) @(negedge clk);
        // once halted the core must stay silent
        repeat (HALT_WATCH) begin
            @(negedge clk);
            if (!halted || mem_rd_req || mem_wr_req || out_valid) begin
                $display("core left halt or made a request at %0t", $time);
                error_count++;
            end
        end
        check_out_count(out_count, exp_out.size());
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_mem_word(addr_t'(i * 4), mem[i], ref_mem[i]);
        end
        $display("summary: %0d outputs seen, %0d expected, %0d errors",
                 out_count, exp_out.size(), error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: project.f
+incdir+tests
design/rv_pkg.sv
design/instr_decode.sv
design/int_alu.sv
design/reg_file.sv
design/core_control.sv
design/rv_core.sv
tests/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core \
    -f project.f -o tb_rv_core_sim
./obj_dir/tb_rv_core_sim | tee sim.log
if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
